/* Makefile */
# Verilator build and run for the operand-only RS unit

TOP = tb_op_rs_unit

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module $(TOP) -f op_rs_unit.f -Mdir obj_dir

# Fails unless the pass line shows up in the simulator output
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir

/* op_rs_unit.f */
src/rs_pkg.sv
src/modn_counter.sv
src/issue_buffer.sv
src/op_only_rs.sv
src/cdb_arbiter.sv
src/op_rs_unit.sv
tests/tb_op_rs_unit.sv

/* src/cdb_arbiter.sv */
// CDB arbiter, round-robin between the RS head and the external EU
`timescale 1ns/100ps
`default_nettype none

module cdb_arbiter (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    // Station request
    input  logic                 rs_valid_i,
    output logic                 rs_grant_o,
    input  rs_pkg::rob_idx_t     rs_tag_i,
    input  rs_pkg::xlen_t        rs_value_i,
    // EU request
    input  logic                 eu_valid_i,
    output logic                 eu_ready_o,
    input  rs_pkg::rob_idx_t     eu_tag_i,
    input  rs_pkg::xlen_t        eu_value_i,
    input  logic                 eu_except_i,
    // CDB broadcast
    output logic                 cdb_valid_o,
    output rs_pkg::rob_idx_t     cdb_tag_o,
    output rs_pkg::xlen_t        cdb_value_o,
    output logic                 cdb_except_o,
    output rs_pkg::except_code_t cdb_ecode_o
);

    import rs_pkg::*;

    // Side that wins the next contested cycle
    rs_state_t prio;
    logic      contest;

    assign contest = rs_valid_i && eu_valid_i;

    // Lone requester wins at once
    assign rs_grant_o  = rs_valid_i && (!eu_valid_i || (prio == PRIO_RS));
    assign eu_ready_o  = eu_valid_i && (!rs_valid_i || (prio == PRIO_EU));
    assign cdb_valid_o = rs_grant_o || eu_ready_o;

    // Bus mux, station fields by default
    assign cdb_tag_o    = eu_ready_o ? eu_tag_i : rs_tag_i;
    assign cdb_value_o  = eu_ready_o ? eu_value_i : rs_value_i;
    // Station never raises, EU sends only the flag
    assign cdb_except_o = eu_ready_o && eu_except_i;
    assign cdb_ecode_o  = E_UNKNOWN;

    // ------------------------------------------------------------------
    // Priority pointer
    // ------------------------------------------------------------------

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prio <= PRIO_RS;
        end else if (contest) begin
            // Loser of this round goes first next time
            prio <= (prio == PRIO_RS) ? PRIO_EU : PRIO_RS;
        end
    end

    // Bus carries a single source per cycle
    a_one_grant: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(rs_grant_o && eu_ready_o));

endmodule

`default_nettype wire

/* src/issue_buffer.sv */
// Issue buffer, two-slot FIFO between decode and the RS that snoops the CDB
`timescale 1ns/100ps
`default_nettype none

module issue_buffer (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             flush_i,
    // Issue side
    input  logic             issue_valid_i,
    output logic             issue_ready_o,
    input  logic             rs1_ready_i,
    input  rs_pkg::rob_idx_t rs1_idx_i,
    input  rs_pkg::xlen_t    rs1_value_i,
    input  rs_pkg::rob_idx_t dest_idx_i,
    // Toward the station
    output logic             buf_valid_o,
    input  logic             buf_ready_i,
    output logic             buf_rs1_ready_o,
    output rs_pkg::rob_idx_t buf_rs1_idx_o,
    output rs_pkg::xlen_t    buf_rs1_value_o,
    output rs_pkg::rob_idx_t buf_dest_idx_o,
    // CDB snoop
    input  logic             cdb_valid_i,
    input  logic             cdb_except_i,
    input  rs_pkg::rob_idx_t cdb_tag_i,
    input  rs_pkg::xlen_t    cdb_value_i
);

    import rs_pkg::*;

    // ------------------------------------------------------------------
    // Storage and control
    // ------------------------------------------------------------------

    // Slot payload
    logic     [1:0] slot_rs1_ready;
    rob_idx_t       slot_rs1_idx   [2];
    xlen_t          slot_rs1_value [2];
    rob_idx_t       slot_dest_idx  [2];

    // Occupancy and pointers
    logic [1:0] count;
    logic       rd_ptr;
    logic       wr_ptr;
    logic       do_push;
    logic       do_pop;

    // Wakeup hits per slot and for the incoming item
    logic [1:0] slot_hit;
    logic       in_hit;
    logic       in_rs1_ready;
    xlen_t      in_rs1_value;

    assign issue_ready_o = (count != 2'd2);
    assign buf_valid_o   = (count != 2'd0);
    assign do_push       = issue_valid_i && issue_ready_o;
    assign do_pop        = buf_valid_o && buf_ready_i;

    // Head slot goes out as is
    assign buf_rs1_ready_o = slot_rs1_ready[rd_ptr];
    assign buf_rs1_idx_o   = slot_rs1_idx[rd_ptr];
    assign buf_rs1_value_o = slot_rs1_value[rd_ptr];
    assign buf_dest_idx_o  = slot_dest_idx[rd_ptr];

    // ------------------------------------------------------------------
    // CDB compare
    // ------------------------------------------------------------------

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            slot_hit[i] = cdb_valid_i && !cdb_except_i && (slot_rs1_idx[i] == cdb_tag_i);
        end
        in_hit = cdb_valid_i && !cdb_except_i && (rs1_idx_i == cdb_tag_i);
        // Incoming item catches a broadcast in its own cycle
        in_rs1_ready = rs1_ready_i || in_hit;
        in_rs1_value = (!rs1_ready_i && in_hit) ? cdb_value_i : rs1_value_i;
    end

    // ------------------------------------------------------------------
    // Pointers and count
    // ------------------------------------------------------------------

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count  <= 2'd0;
            rd_ptr <= 1'b0;
            wr_ptr <= 1'b0;
        end else if (flush_i) begin
            count  <= 2'd0;
            rd_ptr <= 1'b0;
            wr_ptr <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (do_pop) begin
                rd_ptr <= ~rd_ptr;
            end
            // Simultaneous push and pop keep the count
            if (do_push && !do_pop) begin
                count <= count + 2'd1;
            end else if (do_pop && !do_push) begin
                count <= count - 2'd1;
            end
        end
    end

    // ------------------------------------------------------------------
    // Slot update
    // ------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        // Waiting operands wake on a clean matching broadcast
        for (int i = 0; i < 2; i++) begin
            if (!slot_rs1_ready[i] && slot_hit[i]) begin
                slot_rs1_ready[i] <= 1'b1;
                slot_rs1_value[i] <= cdb_value_i;
            end
        end
        // Idle slot is overwritten on push
        if (do_push) begin
            slot_rs1_ready[wr_ptr] <= in_rs1_ready;
            slot_rs1_idx[wr_ptr]   <= rs1_idx_i;
            slot_rs1_value[wr_ptr] <= in_rs1_value;
            slot_dest_idx[wr_ptr]  <= dest_idx_i;
        end
    end

    // Occupancy stays within two slots
    a_count_max: assert property (@(posedge clk_i) disable iff (!rst_n_i) count <= 2'd2);

endmodule

`default_nettype wire

/* src/modn_counter.sv */
// Modulo-N counter with enable and synchronous clear, wraps after N-1
`timescale 1ns/100ps
`default_nettype none

module modn_counter #(
    parameter int unsigned N = 4
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 en_i,
    input  logic                 clr_i,
    output logic [$clog2(N)-1:0] count_o,
    output logic                 tc_o
);

    localparam int unsigned W = $clog2(N);

    // Terminal count, last value before the wrap
    assign tc_o = (count_o == W'(N - 1));

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_o <= '0;
        end else if (clr_i) begin
            // Clear has priority over counting
            count_o <= '0;
        end else if (en_i) begin
            if (tc_o) begin
                count_o <= '0;
            end else begin
                count_o <= count_o + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* src/op_only_rs.sv */
// Operand-only reservation station with parallel CDB capture and in-order retire
`timescale 1ns/100ps
`default_nettype none

module op_only_rs #(
    parameter int unsigned RS_DEPTH = 4
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             flush_i,
    // Push from the issue buffer
    input  logic             push_valid_i,
    output logic             push_ready_o,
    input  logic             rs1_ready_i,
    input  rs_pkg::rob_idx_t rs1_idx_i,
    input  rs_pkg::xlen_t    rs1_value_i,
    input  rs_pkg::rob_idx_t dest_idx_i,
    // Result request toward the CDB arbiter
    output logic             res_valid_o,
    input  logic             pop_grant_i,
    output rs_pkg::rob_idx_t res_tag_o,
    output rs_pkg::xlen_t    res_value_o,
    // CDB snoop
    input  logic             cdb_valid_i,
    input  logic             cdb_except_i,
    input  rs_pkg::rob_idx_t cdb_tag_i,
    input  rs_pkg::xlen_t    cdb_value_i
);

    import rs_pkg::*;

    localparam int unsigned IDX_W = $clog2(RS_DEPTH);

    // ------------------------------------------------------------------
    // Entries and pointers
    // ------------------------------------------------------------------

    // Per-entry status bits
    logic [RS_DEPTH-1:0] ent_valid;
    logic [RS_DEPTH-1:0] ent_rs1_ready;
    logic [RS_DEPTH-1:0] ent_hit;

    // Per-entry payload
    rob_idx_t ent_rs1_idx   [RS_DEPTH];
    xlen_t    ent_rs1_value [RS_DEPTH];
    rob_idx_t ent_dest_idx  [RS_DEPTH];

    // Queue pointers
    logic [IDX_W-1:0] head_idx;
    logic [IDX_W-1:0] tail_idx;

    logic  push;
    logic  pop;
    logic  in_hit;
    logic  in_rs1_ready;
    xlen_t in_rs1_value;

    // Tail entry free means room for one more
    assign push_ready_o = !ent_valid[tail_idx];
    assign push         = push_valid_i && push_ready_o;
    // Only the head may retire
    assign res_valid_o  = ent_valid[head_idx] && ent_rs1_ready[head_idx];
    assign pop          = pop_grant_i;
    assign res_tag_o    = ent_dest_idx[head_idx];
    // Result is the operand itself
    assign res_value_o  = ent_rs1_value[head_idx];

    // ------------------------------------------------------------------
    // CDB compare, all entries in parallel
    // ------------------------------------------------------------------

    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            ent_hit[i] = cdb_valid_i && !cdb_except_i && (ent_rs1_idx[i] == cdb_tag_i);
        end
        // Bypass for the entry being pushed
        in_hit       = cdb_valid_i && !cdb_except_i && (rs1_idx_i == cdb_tag_i);
        in_rs1_ready = rs1_ready_i || in_hit;
        in_rs1_value = (!rs1_ready_i && in_hit) ? cdb_value_i : rs1_value_i;
    end

    // ------------------------------------------------------------------
    // Valid bits
    // ------------------------------------------------------------------

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ent_valid <= '0;
        end else if (flush_i) begin
            ent_valid <= '0;
        end else begin
            if (pop) begin
                ent_valid[head_idx] <= 1'b0;
            end
            if (push) begin
                ent_valid[tail_idx] <= 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    // Operand capture and push
    // ------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (ent_valid[i] && !ent_rs1_ready[i] && ent_hit[i]) begin
                ent_rs1_ready[i] <= 1'b1;
                ent_rs1_value[i] <= cdb_value_i;
            end
        end
        // Tail entry is free, so the push overrides any capture there
        if (push) begin
            ent_rs1_ready[tail_idx] <= in_rs1_ready;
            ent_rs1_idx[tail_idx]   <= rs1_idx_i;
            ent_rs1_value[tail_idx] <= in_rs1_value;
            ent_dest_idx[tail_idx]  <= dest_idx_i;
        end
    end

    // Head and tail pointers, both cleared by flush
    modn_counter #(
        .N (RS_DEPTH)
    ) head_counter_i (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .en_i    (pop),
        .clr_i   (flush_i),
        .count_o (head_idx),
        .tc_o    ()
    );

    modn_counter #(
        .N (RS_DEPTH)
    ) tail_counter_i (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .en_i    (push),
        .clr_i   (flush_i),
        .count_o (tail_idx),
        .tc_o    ()
    );

    // ------------------------------------------------------------------
    // Assertions
    // ------------------------------------------------------------------

    // Arbiter only grants a ready head
    a_grant_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pop_grant_i |-> res_valid_o);

    // Pointers meeting on a push means an empty queue, never a live entry
    a_push_free: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (push && (tail_idx == head_idx)) |-> !(|ent_valid));

endmodule

`default_nettype wire

/* src/op_rs_unit.sv */
// Operand-only RS unit, issue buffer and station sharing the CDB with an EU
`timescale 1ns/100ps
`default_nettype none

module op_rs_unit #(
    parameter int unsigned RS_DEPTH = 4
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 flush_i,
    // Issue from decode
    input  logic                 issue_valid_i,
    output logic                 issue_ready_o,
    input  logic                 rs1_ready_i,
    input  rs_pkg::rob_idx_t     rs1_idx_i,
    input  rs_pkg::xlen_t        rs1_value_i,
    input  rs_pkg::rob_idx_t     dest_idx_i,
    // External EU result
    input  logic                 eu_valid_i,
    output logic                 eu_ready_o,
    input  rs_pkg::rob_idx_t     eu_tag_i,
    input  rs_pkg::xlen_t        eu_value_i,
    input  logic                 eu_except_i,
    // CDB
    output logic                 cdb_valid_o,
    output rs_pkg::rob_idx_t     cdb_tag_o,
    output rs_pkg::xlen_t        cdb_value_o,
    output logic                 cdb_except_o,
    output rs_pkg::except_code_t cdb_ecode_o
);

    import rs_pkg::*;

    // Buffer to station
    logic     buf_valid;
    logic     buf_ready;
    logic     buf_rs1_ready;
    rob_idx_t buf_rs1_idx;
    xlen_t    buf_rs1_value;
    rob_idx_t buf_dest_idx;

    // Station to arbiter
    logic     rs_valid;
    logic     rs_grant;
    rob_idx_t rs_tag;
    xlen_t    rs_value;

    // ------------------------------------------------------------------
    // Input side
    // ------------------------------------------------------------------

    issue_buffer issue_buffer_i (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .flush_i         (flush_i),
        .issue_valid_i   (issue_valid_i),
        .issue_ready_o   (issue_ready_o),
        .rs1_ready_i     (rs1_ready_i),
        .rs1_idx_i       (rs1_idx_i),
        .rs1_value_i     (rs1_value_i),
        .dest_idx_i      (dest_idx_i),
        .buf_valid_o     (buf_valid),
        .buf_ready_i     (buf_ready),
        .buf_rs1_ready_o (buf_rs1_ready),
        .buf_rs1_idx_o   (buf_rs1_idx),
        .buf_rs1_value_o (buf_rs1_value),
        .buf_dest_idx_o  (buf_dest_idx),
        .cdb_valid_i     (cdb_valid_o),
        .cdb_except_i    (cdb_except_o),
        .cdb_tag_i       (cdb_tag_o),
        .cdb_value_i     (cdb_value_o)
    );

    // ------------------------------------------------------------------
    // Reservation station
    // ------------------------------------------------------------------

    op_only_rs #(
        .RS_DEPTH (RS_DEPTH)
    ) op_only_rs_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .push_valid_i (buf_valid),
        .push_ready_o (buf_ready),
        .rs1_ready_i  (buf_rs1_ready),
        .rs1_idx_i    (buf_rs1_idx),
        .rs1_value_i  (buf_rs1_value),
        .dest_idx_i   (buf_dest_idx),
        .res_valid_o  (rs_valid),
        .pop_grant_i  (rs_grant),
        .res_tag_o    (rs_tag),
        .res_value_o  (rs_value),
        .cdb_valid_i  (cdb_valid_o),
        .cdb_except_i (cdb_except_o),
        .cdb_tag_i    (cdb_tag_o),
        .cdb_value_i  (cdb_value_o)
    );

    // ------------------------------------------------------------------
    // Output side, broadcast also feeds the wakeup path above
    // ------------------------------------------------------------------

    cdb_arbiter cdb_arbiter_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .rs_valid_i   (rs_valid),
        .rs_grant_o   (rs_grant),
        .rs_tag_i     (rs_tag),
        .rs_value_i   (rs_value),
        .eu_valid_i   (eu_valid_i),
        .eu_ready_o   (eu_ready_o),
        .eu_tag_i     (eu_tag_i),
        .eu_value_i   (eu_value_i),
        .eu_except_i  (eu_except_i),
        .cdb_valid_o  (cdb_valid_o),
        .cdb_tag_o    (cdb_tag_o),
        .cdb_value_o  (cdb_value_o),
        .cdb_except_o (cdb_except_o),
        .cdb_ecode_o  (cdb_ecode_o)
    );

endmodule

`default_nettype wire

/* src/rs_pkg.sv */
// Operand-only RS package with datapath widths, ROB tag and CDB exception types
`default_nettype none

package rs_pkg;

    // ------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------

    // Operand and result width
    localparam int unsigned XLEN = 32;
    // ROB tag width
    localparam int unsigned ROB_IDX_LEN = 5;

    // One operand or result word
    typedef logic [XLEN-1:0] xlen_t;
    // ROB entry tag
    typedef logic [ROB_IDX_LEN-1:0] rob_idx_t;
    // Exception cause carried on the CDB
    typedef logic [3:0] except_code_t;

    // Cause attached to every station result
    localparam except_code_t E_UNKNOWN = 4'hF;

    // CDB arbiter priority pointer
    typedef enum logic {
        PRIO_RS,
        PRIO_EU
    } rs_state_t;

endpackage

`default_nettype wire

/* tests/tb_op_rs_unit.sv */
// Testbench for the operand-only RS unit, random fixed-seed traffic against a reference queue
`timescale 1ns/100ps
`default_nettype none

module tb_op_rs_unit;

    import rs_pkg::*;

    localparam int unsigned CLK_HALF    = 10;
    // Upper bound on items issued over all phases
    localparam int unsigned ITEM_BUDGET = 160;

    // One issued instruction as the model sees it
    typedef struct packed {
        logic [4:0]  dest;
        logic [4:0]  rs1;
        logic        resolved;
        logic [31:0] value;
    } item_t;

    // ------------------------------------------------------------------
    // DUT ports
    // ------------------------------------------------------------------

    logic         clk_i;
    logic         rst_n_i;
    logic         flush_i;
    logic         issue_valid_i;
    logic         issue_ready_o;
    logic         rs1_ready_i;
    rob_idx_t     rs1_idx_i;
    xlen_t        rs1_value_i;
    rob_idx_t     dest_idx_i;
    logic         eu_valid_i;
    logic         eu_ready_o;
    rob_idx_t     eu_tag_i;
    xlen_t        eu_value_i;
    logic         eu_except_i;
    logic         cdb_valid_o;
    rob_idx_t     cdb_tag_o;
    xlen_t        cdb_value_o;
    logic         cdb_except_o;
    except_code_t cdb_ecode_o;

    // ------------------------------------------------------------------
    // Model state
    // ------------------------------------------------------------------

    item_t       ref_q[$];
    // Waiting tags whose producer may broadcast
    rob_idx_t    eu_list[$];
    logic [31:0] tag_busy;
    item_t       next_item;
    bit          item_pending;
    bit          issue_hold;
    bit          eu_done;
    bit          eu_lost_prev;
    bit          flush_prev;
    int unsigned next_dest;
    int unsigned issued;
    // Scenario counters
    int unsigned contest_cnt;
    int unsigned same_cycle_cnt;
    int unsigned except_cnt;
    int unsigned ready_low_cnt;

    op_rs_unit op_rs_unit_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .issue_valid_i (issue_valid_i),
        .issue_ready_o (issue_ready_o),
        .rs1_ready_i   (rs1_ready_i),
        .rs1_idx_i     (rs1_idx_i),
        .rs1_value_i   (rs1_value_i),
        .dest_idx_i    (dest_idx_i),
        .eu_valid_i    (eu_valid_i),
        .eu_ready_o    (eu_ready_o),
        .eu_tag_i      (eu_tag_i),
        .eu_value_i    (eu_value_i),
        .eu_except_i   (eu_except_i),
        .cdb_valid_o   (cdb_valid_o),
        .cdb_tag_o     (cdb_tag_o),
        .cdb_value_o   (cdb_value_o),
        .cdb_except_o  (cdb_except_o),
        .cdb_ecode_o   (cdb_ecode_o)
    );

    always #(CLK_HALF) clk_i = ~clk_i;

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string sig, input logic [31:0] got,
                                   input logic [31:0] exp);
        stop_with_error($sformatf("ERROR %s: got 0x%h, expected 0x%h", sig, got, exp));
    endtask

    // New instruction, dest tags cycle through 0..15
    task automatic make_instr(input int unsigned wait_pct);
        rob_idx_t free_tags[$];
        for (int t = 16; t < 32; t++) begin
            if (!tag_busy[t]) begin
                free_tags.push_back(rob_idx_t'(t));
            end
        end
        next_item.dest  = rob_idx_t'(next_dest);
        next_item.value = $urandom;
        next_dest       = (next_dest + 1) % 16;
        if ($urandom_range(99) < wait_pct && free_tags.size() != 0) begin
            next_item.rs1      = free_tags[$urandom_range(free_tags.size() - 1)];
            next_item.resolved = 1'b0;
            tag_busy[next_item.rs1] = 1'b1;
        end else begin
            // Ready operand, its tag must be ignored by any broadcast
            next_item.rs1      = rob_idx_t'($urandom_range(31, 16));
            next_item.resolved = 1'b1;
        end
        item_pending = 1'b1;
    endtask

    // ------------------------------------------------------------------
    // Falling edge, drive issue, EU and flush
    // ------------------------------------------------------------------

    task automatic drive_inputs(input int unsigned wait_pct, input bit new_en,
                                input bit eu_en, input bit do_flush);
        int unsigned pick;
        bit          fresh;
        @(negedge clk_i);
        fresh   = 1'b0;
        flush_i = do_flush;
        if (eu_done) begin
            eu_valid_i = 1'b0;
            eu_done    = 1'b0;
        end
        if (!item_pending && new_en && $urandom_range(3) != 0) begin
            make_instr(wait_pct);
        end
        issue_valid_i = item_pending && !issue_hold && !do_flush;
        rs1_ready_i   = next_item.resolved;
        rs1_idx_i     = next_item.rs1;
        rs1_value_i   = next_item.value;
        dest_idx_i    = next_item.dest;
        // issue_ready_o comes from registered state, so the item is taken at the next edge
        if (issue_valid_i && issue_ready_o && !next_item.resolved) begin
            eu_list.push_back(next_item.rs1);
            fresh = 1'b1;
        end
        // EU holds a request stable until eu_ready_o
        if (!eu_valid_i && eu_en && eu_list.size() != 0 && $urandom_range(3) != 0) begin
            pick = $urandom_range(eu_list.size() - 1);
            // Newest tag now and then, aims at the accept cycle itself
            if (fresh && $urandom_range(1) == 1) begin
                pick = eu_list.size() - 1;
            end
            eu_valid_i = 1'b1;
            eu_tag_i   = eu_list[pick];
            eu_value_i = $urandom;
            if ($urandom_range(3) == 0) begin
                // Excepted copy, tag stays pending
                eu_except_i = 1'b1;
            end else begin
                eu_except_i = 1'b0;
                eu_list.delete(pick);
            end
        end
    endtask

    // ------------------------------------------------------------------
    // Rising edge, check the CDB and update the model
    // ------------------------------------------------------------------

    task automatic sample_outputs();
        item_t front;
        @(posedge clk_i);
        // After a lost contest the EU owns the next one
        if (eu_lost_prev && eu_valid_i) begin
            assert (eu_ready_o) else stop_with_error("EU lost the CDB twice in a row");
        end
        eu_lost_prev = eu_valid_i && !eu_ready_o;
        if (eu_lost_prev) begin
            contest_cnt++;
        end
        assert (eu_valid_i || !eu_ready_o)
            else stop_with_error("eu_ready_o high with no EU request");
        if (flush_prev) begin
            assert (issue_ready_o) else report_mismatch("issue_ready_o", 32'(issue_ready_o), 32'd1);
        end
        flush_prev = flush_i;
        if (!issue_ready_o) begin
            ready_low_cnt++;
        end
        if (eu_valid_i && eu_ready_o) begin
            assert (cdb_valid_o) else report_mismatch("cdb_valid_o", 32'(cdb_valid_o), 32'd1);
            assert (cdb_tag_o == eu_tag_i)
                else report_mismatch("cdb_tag_o", 32'(cdb_tag_o), 32'(eu_tag_i));
            assert (cdb_value_o == eu_value_i)
                else report_mismatch("cdb_value_o", cdb_value_o, eu_value_i);
            assert (cdb_except_o == eu_except_i)
                else report_mismatch("cdb_except_o", 32'(cdb_except_o), 32'(eu_except_i));
            eu_done = 1'b1;
        end else if (cdb_valid_o) begin
            // Station result, must be the oldest outstanding item
            assert (ref_q.size() != 0) else stop_with_error("station result with nothing issued");
            front = ref_q.pop_front();
            assert (cdb_tag_o == front.dest)
                else report_mismatch("cdb_tag_o", 32'(cdb_tag_o), 32'(front.dest));
            assert (front.resolved) else stop_with_error("station result before its operand woke");
            assert (cdb_value_o == front.value)
                else report_mismatch("cdb_value_o", cdb_value_o, front.value);
            assert (!cdb_except_o) else report_mismatch("cdb_except_o", 32'(cdb_except_o), 32'd0);
            assert (cdb_ecode_o == E_UNKNOWN)
                else report_mismatch("cdb_ecode_o", 32'(cdb_ecode_o), 32'(E_UNKNOWN));
        end
        if (issue_valid_i && issue_ready_o) begin
            ref_q.push_back(next_item);
            item_pending = 1'b0;
            issued++;
        end
        // First clean result of a tag is the operand value
        if (eu_valid_i && eu_ready_o) begin
            if (eu_except_i) begin
                except_cnt++;
            end else begin
                for (int i = 0; i < ref_q.size(); i++) begin
                    if (!ref_q[i].resolved && ref_q[i].rs1 == eu_tag_i) begin
                        ref_q[i].value    = eu_value_i;
                        ref_q[i].resolved = 1'b1;
                    end
                end
                tag_busy[eu_tag_i] = 1'b0;
                if (issue_valid_i && issue_ready_o && !rs1_ready_i && rs1_idx_i == eu_tag_i) begin
                    same_cycle_cnt++;
                end
            end
        end
        if (flush_i) begin
            ref_q.delete();
        end
    endtask

    task automatic run_cycle(input int unsigned wait_pct, input bit new_en,
                             input bit eu_en, input bit do_flush);
        drive_inputs(wait_pct, new_en, eu_en, do_flush);
        sample_outputs();
    endtask

    // Run until every item and every EU result is out
    task automatic drain();
        while (ref_q.size() != 0 || item_pending || eu_list.size() != 0 || eu_valid_i) begin
            run_cycle(0, 1'b0, 1'b1, 1'b0);
        end
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------

    initial begin
        int unsigned base;
        int unsigned low_base;
        int unsigned gaps;
        void'($urandom(71));
        clk_i         = 1'b0;
        rst_n_i       = 1'b0;
        flush_i       = 1'b0;
        issue_valid_i = 1'b0;
        rs1_ready_i   = 1'b0;
        rs1_idx_i     = '0;
        rs1_value_i   = '0;
        dest_idx_i    = '0;
        eu_valid_i    = 1'b0;
        eu_tag_i      = '0;
        eu_value_i    = '0;
        eu_except_i   = 1'b0;
        next_item     = '0;
        tag_busy      = '0;
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        @(posedge clk_i);
        assert (issue_ready_o) else report_mismatch("issue_ready_o", 32'(issue_ready_o), 32'd1);
        assert (!cdb_valid_o) else report_mismatch("cdb_valid_o", 32'(cdb_valid_o), 32'd0);
        assert (!eu_ready_o) else report_mismatch("eu_ready_o", 32'(eu_ready_o), 32'd0);

        // Ready operands only, EU quiet
        while (issued < 30) run_cycle(0, 1'b1, 1'b0, 1'b0);
        // Mixed operands with EU traffic
        while (issued < 110) run_cycle(50, 1'b1, 1'b1, 1'b0);
        drain();

        // EU stalled, station and buffer fill up
        base     = issued;
        low_base = ready_low_cnt;
        while (ready_low_cnt == low_base && issued < base + 12) begin
            run_cycle(100, 1'b1, 1'b0, 1'b0);
        end
        assert (ready_low_cnt != low_base)
            else stop_with_error("issue_ready_o never dropped while the EU was stalled");
        repeat (5) run_cycle(100, 1'b0, 1'b0, 1'b0);
        drain();

        // Flush with waiting items inside, then a quiet stretch
        repeat (10) run_cycle(100, 1'b1, 1'b0, 1'b0);
        run_cycle(0, 1'b0, 1'b0, 1'b1);
        issue_hold = 1'b1;
        repeat (8) run_cycle(0, 1'b0, 1'b1, 1'b0);
        issue_hold = 1'b0;
        base = issued;
        while (issued < base + 6) run_cycle(50, 1'b1, 1'b1, 1'b0);
        drain();

        gaps = 0;
        if (contest_cnt == 0 || same_cycle_cnt == 0) begin
            $display("No CDB contest or no wakeup in the accept cycle was seen");
            gaps++;
        end
        if (except_cnt == 0 || ready_low_cnt == 0) begin
            $display("No excepted EU result or no full issue buffer was seen");
            gaps++;
        end
        if (gaps == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            stop_with_error("Test run missed some of its target scenarios");
        end
    end

    // Watchdog, 200 cycles for each item in the budget
    initial begin
        #(2 * CLK_HALF * 200 * ITEM_BUDGET);
        stop_with_error("Timeout: the tests did not finish in the allowed number of cycles");
    end

endmodule

`default_nettype wire
